// ==== verilog/laser310_pkg.sv ====
// Shared address map and bus types for the Laser 310 CPU side
package laser310_pkg;

	// Bus widths
	localparam int ADDR_W = 16;		// Z80 address bus
	localparam int DATA_W = 8;		// Z80 data bus

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	// Decoded target of one access
	typedef enum logic [1:0]
	{
		REG_NONE = 2'd0,	// Unmapped, reads FFh
		REG_IO   = 2'd1,	// Keyboard and output latch
		REG_VRAM = 2'd2,	// 2 KB video RAM
		REG_RAM  = 2'd3		// 16 KB base RAM
	} region_e;

	// Memory map
	// 6800 -- 6FFF I/O, any address in the window hits the latch
	// 7000 -- 77FF VRAM 2KB
	// 7800 -- B7FF RAM 16KB
	localparam addr_t IO_BASE   = 16'h6800;	// Top five bits 01101
	localparam addr_t VRAM_BASE = 16'h7000;	// Top five bits 01110
	localparam addr_t RAM_BASE  = 16'h7800;
	localparam addr_t RAM_TOP   = 16'hB7FF;	// Last base RAM byte

	// Keyboard matrix geometry
	// Row r is selected by address bit r low, column k is data bit k
	localparam int KEY_ROWS = 8;
	localparam int KEY_COLS = 8;

	// Active low, 1 means released
	// Bit index is row*8 + column
	typedef logic [KEY_ROWS*KEY_COLS-1:0] key_mat_t;

	// Floating bus value
	localparam byte_t UNMAPPED_DATA = 8'hFF;

endpackage

// ==== verilog/mem_bank.sv ====
`timescale 1ns/1ps

// Video RAM and base RAM with registered reads
module mem_bank
#(
	parameter int VRAM_AW = 11,
	parameter int RAM_AW  = 14
)
(
	input  logic					CLK50MHZ,
	input  laser310_pkg::region_e	region_i,
	input  laser310_pkg::addr_t		addr_i,
	input  laser310_pkg::byte_t		wdata_i,
	input  logic					we_i,
	output laser310_pkg::byte_t		rdata_o
);

	localparam int VRAM_DEPTH = 2**VRAM_AW;
	localparam int RAM_DEPTH  = 2**RAM_AW;

	laser310_pkg::byte_t	vram [VRAM_DEPTH];	// 7000h window
	laser310_pkg::byte_t	ram [RAM_DEPTH];	// 7800h window

	laser310_pkg::addr_t	ram_off;			// Offset from RAM_BASE
	logic [VRAM_AW-1:0]		vram_idx;
	logic [RAM_AW-1:0]		ram_idx;
	laser310_pkg::byte_t	vram_q;
	laser310_pkg::byte_t	ram_q;
	logic					sel_vram_q;			// Read source of last edge

	// Region to array offset
	assign ram_off = addr_i - laser310_pkg::RAM_BASE;
	assign vram_idx = addr_i[VRAM_AW-1:0];		// A0..A10 for 2 KB
	assign ram_idx = ram_off[RAM_AW-1:0];

	// Video RAM port
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i && (region_i == laser310_pkg::REG_VRAM))
			vram[vram_idx] <= wdata_i;
		vram_q <= vram[vram_idx];
	end

	// Base RAM port
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i && (region_i == laser310_pkg::REG_RAM))
			ram[ram_idx] <= wdata_i;
		ram_q <= ram[ram_idx];
	end

	// Remember which array was addressed
	always_ff @(posedge CLK50MHZ)
	begin
		sel_vram_q <= (region_i == laser310_pkg::REG_VRAM);
	end

	assign rdata_o = sel_vram_q ? vram_q : ram_q;

endmodule

// ==== verilog/key_matrix.sv ====
`timescale 1ns/1ps

// PS/2 scan codes into the 8x8 Laser 310 key matrix
//
//     KD5 KD4 KD3 KD2  KD1 KD0
// A0  R   Q   E        W   T
// A1  F   A   D   CTRL S   G
// A2  V   Z   C   SHFT X   B
// A4  M   SPC          .   N
// A6  U   P   I   RETN O   Y
// A7  J       K        L   H
module key_matrix
(
	input  logic					CLK50MHZ,
	input  logic					RESET_N,
	input  logic					key_strobe_i,	// One cycle per event
	input  logic					key_pressed_i,	// 1 press, 0 release
	input  laser310_pkg::byte_t		key_code_i,
	input  laser310_pkg::byte_t		row_sel_i,		// Active low row select
	output logic [5:0]				row_data_o		// Active low columns
);

	localparam int KEY_IDX_W = $clog2(laser310_pkg::KEY_ROWS * laser310_pkg::KEY_COLS);

	laser310_pkg::key_mat_t		key_q;
	logic						key_hit;		// Code is one of the mapped keys
	logic [KEY_IDX_W-1:0]		key_idx;		// row*8 + column

	// Scan code to matrix position
	always_comb
	begin
		key_hit = 1'b1;
		key_idx = '0;
		case (key_code_i)
			8'h2C: key_idx = 6'd0;		// T
			8'h1D: key_idx = 6'd1;		// W
			8'h24: key_idx = 6'd3;		// E
			8'h15: key_idx = 6'd4;		// Q
			8'h2D: key_idx = 6'd5;		// R
			8'h34: key_idx = 6'd8;		// G
			8'h1B: key_idx = 6'd9;		// S
			8'h14: key_idx = 6'd10;		// Ctrl
			8'h23: key_idx = 6'd11;		// D
			8'h1C: key_idx = 6'd12;		// A
			8'h2B: key_idx = 6'd13;		// F
			8'h32: key_idx = 6'd16;		// B
			8'h22: key_idx = 6'd17;		// X
			8'h12: key_idx = 6'd18;		// Left shift
			8'h21: key_idx = 6'd19;		// C
			8'h1A: key_idx = 6'd20;		// Z
			8'h2A: key_idx = 6'd21;		// V
			8'h31: key_idx = 6'd32;		// N
			8'h29: key_idx = 6'd36;		// Space
			8'h3A: key_idx = 6'd37;		// M
			8'h35: key_idx = 6'd48;		// Y
			8'h44: key_idx = 6'd49;		// O
			8'h5A: key_idx = 6'd50;		// Return
			8'h43: key_idx = 6'd51;		// I
			8'h4D: key_idx = 6'd52;		// P
			8'h3C: key_idx = 6'd53;		// U
			8'h33: key_idx = 6'd56;		// H
			8'h4B: key_idx = 6'd57;		// L
			8'h42: key_idx = 6'd59;		// K
			8'h3B: key_idx = 6'd61;		// J
			default: key_hit = 1'b0;	// Unmapped keys ignored
		endcase
	end

	// Key state, cleared bit means held down
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			key_q <= '1;				// All released
		else if (key_strobe_i && key_hit)
			key_q[key_idx] <= ~key_pressed_i;
	end

	// Column k reads low if a selected row holds a pressed key there
	// Several rows may be selected at once
	always_comb
	begin
		logic [laser310_pkg::KEY_ROWS-1:0] col_bits;
		for (int k = 0; k < 6; k++)
		begin
			for (int r = 0; r < laser310_pkg::KEY_ROWS; r++)
				col_bits[r] = key_q[r*laser310_pkg::KEY_COLS + k];
			row_data_o[k] = &(row_sel_i | col_bits);	// Deselected rows mask
		end
	end

endmodule

// ==== verilog/wb_bus_ctrl.sv ====
`timescale 1ns/1ps

// Wishbone slave standing in for the Z80 bus cycle
// Decode, output latch at 6800h and read data assembly
module wb_bus_ctrl
(
	input  logic					CLK50MHZ,
	input  logic					RESET_N,
	// Wishbone classic slave
	input  logic					wb_cyc_i,
	input  logic					wb_stb_i,
	input  logic					wb_we_i,
	input  laser310_pkg::addr_t		wb_adr_i,
	input  laser310_pkg::byte_t		wb_dat_i,
	output laser310_pkg::byte_t		wb_dat_o,
	output logic					wb_ack_o,
	// RAM bank side
	output laser310_pkg::region_e	mem_region_o,
	output laser310_pkg::addr_t		mem_addr_o,
	output laser310_pkg::byte_t		mem_wdata_o,
	output logic					mem_we_o,
	input  laser310_pkg::byte_t		mem_rdata_i,
	// Keyboard side
	output laser310_pkg::byte_t		kb_row_sel_o,
	input  logic [5:0]				kb_row_data_i,
	// Cassette and latch pins
	input  logic					cass_in_i,
	output logic [1:0]				spk_o,
	output logic					cass_out_o,
	output logic					vdg_ag_o,
	output logic					vdg_css_o
);

	// Access phases
	localparam logic [1:0] PH_IDLE = 2'd0;	// Waiting for stb
	localparam logic [1:0] PH_DATA = 2'd1;	// Memory read in flight
	localparam logic [1:0] PH_HOLD = 2'd2;	// Ack sent, wait for stb low

	logic [1:0]				phase_q;
	logic					ack_q;
	logic					req_start;		// Request accepted this edge
	laser310_pkg::region_e	region;
	laser310_pkg::byte_t	latch_q;		// I/O output latch
	laser310_pkg::byte_t	rd_mux;
	laser310_pkg::byte_t	dat_q;

	// Region decode, address is stable while stb is high
	always_comb
	begin
		region = laser310_pkg::REG_NONE;
		if (wb_adr_i[laser310_pkg::ADDR_W-1 -: 5] ==
			laser310_pkg::IO_BASE[laser310_pkg::ADDR_W-1 -: 5])
			region = laser310_pkg::REG_IO;
		else if (wb_adr_i[laser310_pkg::ADDR_W-1 -: 5] ==
			laser310_pkg::VRAM_BASE[laser310_pkg::ADDR_W-1 -: 5])
			region = laser310_pkg::REG_VRAM;
		else if ((wb_adr_i >= laser310_pkg::RAM_BASE) && (wb_adr_i <= laser310_pkg::RAM_TOP))
			region = laser310_pkg::REG_RAM;
	end

	assign req_start = wb_cyc_i && wb_stb_i && (phase_q == PH_IDLE);

	// Phase counter, ack and output latch
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase_q	<= PH_IDLE;
			ack_q	<= 1'b0;
			latch_q	<= '0;		// Speaker, cassette and VDG bits low
		end
		else
		begin
			ack_q <= (phase_q == PH_DATA);	// Single pulse, 2nd edge
			case (phase_q)
				PH_IDLE:
				begin
					if (req_start)
						phase_q <= PH_DATA;
				end
				PH_DATA:
					phase_q <= PH_HOLD;
				default:
				begin
					// Held request is not taken twice
					if (!wb_stb_i)
						phase_q <= PH_IDLE;
				end
			endcase
			if (req_start && wb_we_i && (region == laser310_pkg::REG_IO))
				latch_q <= wb_dat_i;	// Any address in 6800h-6FFFh
		end
	end

	// Read byte selection
	always_comb
	begin
		case (region)
			laser310_pkg::REG_IO:
				rd_mux = {1'b1, ~cass_in_i, kb_row_data_i};	// Bit 7 floats high
			laser310_pkg::REG_VRAM,
			laser310_pkg::REG_RAM:
				rd_mux = mem_rdata_i;
			default:
				rd_mux = laser310_pkg::UNMAPPED_DATA;
		endcase
	end

	// Read data lands with ack
	always_ff @(posedge CLK50MHZ)
	begin
		if (phase_q == PH_DATA)
			dat_q <= rd_mux;
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;

	// To RAM bank
	assign mem_region_o = region;
	assign mem_addr_o = wb_adr_i;
	assign mem_wdata_o = wb_dat_i;
	assign mem_we_o = req_start && wb_we_i;	// Bank filters on region

	assign kb_row_sel_o = wb_adr_i[7:0];		// A0..A7 select rows

	// Latch bit mapping
	assign spk_o = {latch_q[0], latch_q[5]};
	assign cass_out_o = latch_q[2];
	assign vdg_ag_o = latch_q[3];				// Graphics mode
	assign vdg_css_o = latch_q[4];				// Colour set

endmodule

// ==== verilog/laser310_top.sv ====
`timescale 1ns/1ps

// CPU-facing map of the Laser 310, driven from a Wishbone classic slave
module laser310_top
#(
	parameter int VRAM_AW = 11,		// 2 KB video RAM
	parameter int RAM_AW  = 14		// 16 KB base RAM
)
(
	input  logic					CLK50MHZ,
	input  logic					RESET_N,		// Async, active low
	// Wishbone classic slave
	input  logic					wb_cyc_i,
	input  logic					wb_stb_i,
	input  logic					wb_we_i,
	input  laser310_pkg::addr_t		wb_adr_i,
	input  laser310_pkg::byte_t		wb_dat_i,
	output laser310_pkg::byte_t		wb_dat_o,
	output logic					wb_ack_o,
	// Strobed PS/2 scan codes
	input  logic					key_strobe_i,
	input  logic					key_pressed_i,
	input  laser310_pkg::byte_t		key_code_i,
	// Cassette and latch pins
	input  logic					cass_in_i,
	output logic [1:0]				spk_o,
	output logic					cass_out_o,
	output logic					vdg_ag_o,
	output logic					vdg_css_o
);

	// Bus controller to RAM bank
	laser310_pkg::region_e	mem_region;
	laser310_pkg::addr_t	mem_addr;
	laser310_pkg::byte_t	mem_wdata;
	logic					mem_we;			// One cycle per write
	laser310_pkg::byte_t	mem_rdata;		// Registered read

	// Bus controller to keyboard
	laser310_pkg::byte_t	kb_row_sel;		// Low address byte
	logic [5:0]				kb_row_data;

	wb_bus_ctrl u_bus
	(
		.CLK50MHZ		(CLK50MHZ),
		.RESET_N		(RESET_N),
		.wb_cyc_i		(wb_cyc_i),
		.wb_stb_i		(wb_stb_i),
		.wb_we_i		(wb_we_i),
		.wb_adr_i		(wb_adr_i),
		.wb_dat_i		(wb_dat_i),
		.wb_dat_o		(wb_dat_o),
		.wb_ack_o		(wb_ack_o),
		.mem_region_o	(mem_region),
		.mem_addr_o		(mem_addr),
		.mem_wdata_o	(mem_wdata),
		.mem_we_o		(mem_we),
		.mem_rdata_i	(mem_rdata),
		.kb_row_sel_o	(kb_row_sel),
		.kb_row_data_i	(kb_row_data),
		.cass_in_i		(cass_in_i),
		.spk_o			(spk_o),
		.cass_out_o		(cass_out_o),
		.vdg_ag_o		(vdg_ag_o),
		.vdg_css_o		(vdg_css_o)
	);

	mem_bank #(.VRAM_AW(VRAM_AW), .RAM_AW(RAM_AW)) u_mem
	(
		.CLK50MHZ		(CLK50MHZ),
		.region_i		(mem_region),
		.addr_i			(mem_addr),
		.wdata_i		(mem_wdata),
		.we_i			(mem_we),
		.rdata_o		(mem_rdata)
	);

	key_matrix u_keys
	(
		.CLK50MHZ		(CLK50MHZ),
		.RESET_N		(RESET_N),
		.key_strobe_i	(key_strobe_i),
		.key_pressed_i	(key_pressed_i),
		.key_code_i		(key_code_i),
		.row_sel_i		(kb_row_sel),
		.row_data_o		(kb_row_data)
	);

endmodule

// ==== tb/laser310_properties.sv ====
`timescale 1ns/1ps

// Wishbone handshake rules, bound into every wb_bus_ctrl
module laser310_properties
(
	input  logic	CLK50MHZ,
	input  logic	RESET_N,
	input  logic	wb_cyc_i,
	input  logic	wb_stb_i,
	input  logic	wb_ack_o
);

	// Single cycle pulse per access
	ack_one_cycle: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb_ack_o high for more than one cycle");

	ack_with_stb: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o without an active request");

	// Held low by the async reset
	ack_in_reset: assert property (@(posedge CLK50MHZ) !RESET_N |-> !wb_ack_o)
		else $error("wb_ack_o high during reset");

endmodule

bind wb_bus_ctrl laser310_properties u_props
(
	.CLK50MHZ	(CLK50MHZ),
	.RESET_N	(RESET_N),
	.wb_cyc_i	(wb_cyc_i),
	.wb_stb_i	(wb_stb_i),
	.wb_ack_o	(wb_ack_o)
);

// ==== tb/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Compare tasks, included into tb_laser310

// Read data or any other byte wide result
task automatic check_byte(input string name, input laser310_pkg::byte_t got,
	input laser310_pkg::byte_t exp);
	if (got !== exp)
		report_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
endtask

// Latch pins against the byte last written to the I/O window
task automatic check_latch(input laser310_pkg::byte_t exp);
	logic [1:0] exp_spk;
	exp_spk = {exp[0], exp[5]};			// Speaker pair, bits 0 and 5
	if (spk !== exp_spk)
		report_failure($sformatf("FAILED spk_o got %h expected %h", spk, exp_spk));
	if (cass_out !== exp[2])
		report_failure($sformatf("FAILED cass_out_o got %h expected %h", cass_out, exp[2]));
	if (vdg_ag !== exp[3])
		report_failure($sformatf("FAILED vdg_ag_o got %h expected %h", vdg_ag, exp[3]));
	if (vdg_css !== exp[4])
		report_failure($sformatf("FAILED vdg_css_o got %h expected %h", vdg_css, exp[4]));
endtask

// Cycles from request to sampled ack
task automatic check_ack(input int cycles);
	if (cycles != ACK_LATENCY)
		report_failure($sformatf("FAILED wb_ack_o latency got %h expected %h",
			cycles, ACK_LATENCY));
endtask

`endif

// ==== tb/tb_laser310.sv ====
`timescale 1ns/1ps

// Table driven testbench, expected bytes from a model of the memory map
module tb_laser310;

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_MARGIN = 100;
	localparam int ACK_LATENCY = 2;		// Request edge to ack sample
	localparam int VRAM_AW = 11;
	localparam int RAM_AW = 14;
	localparam int KEY_COUNT = 30;

	// Scan code and its row*8+column position
	localparam laser310_pkg::byte_t KEY_CODES [KEY_COUNT] = '{
		8'h2C, 8'h1D, 8'h24, 8'h15, 8'h2D, 8'h34, 8'h1B, 8'h14, 8'h23, 8'h1C,
		8'h2B, 8'h32, 8'h22, 8'h12, 8'h21, 8'h1A, 8'h2A, 8'h31, 8'h29, 8'h3A,
		8'h35, 8'h44, 8'h5A, 8'h43, 8'h4D, 8'h3C, 8'h33, 8'h4B, 8'h42, 8'h3B};
	localparam logic [5:0] KEY_POS [KEY_COUNT] = '{
		6'd0, 6'd1, 6'd3, 6'd4, 6'd5, 6'd8, 6'd9, 6'd10, 6'd11, 6'd12,
		6'd13, 6'd16, 6'd17, 6'd18, 6'd19, 6'd20, 6'd21, 6'd32, 6'd36, 6'd37,
		6'd48, 6'd49, 6'd50, 6'd51, 6'd52, 6'd53, 6'd56, 6'd57, 6'd59, 6'd61};

	typedef enum {OP_WR, OP_WR_IO, OP_RD, OP_KEY, OP_CASS} op_e;
	typedef struct
	{
		op_e					op;
		laser310_pkg::addr_t	addr;
		laser310_pkg::byte_t	data;	// Write byte, cassette level in bit 0
		laser310_pkg::byte_t	code;
		logic					press;
		laser310_pkg::byte_t	exp;	// Read byte, or latch after a write
	} step_t;

	logic CLK50MHZ, RESET_N, wb_cyc, wb_stb, wb_we, wb_ack;
	logic key_strobe, key_pressed, cass_in, cass_out, vdg_ag, vdg_css;
	logic [1:0] spk;
	laser310_pkg::addr_t wb_adr;
	laser310_pkg::byte_t wb_wdat, wb_rdat, key_code;

	// Reference model
	laser310_pkg::byte_t vram_m [2**VRAM_AW];
	laser310_pkg::byte_t ram_m [2**RAM_AW];
	laser310_pkg::byte_t latch_m = 8'h00;
	laser310_pkg::key_mat_t keys_m = '1;	// All released
	logic cass_m = 1'b0;

	step_t steps[$];
	logic [31:0] lcg_state = 32'h5441;
	int cycle_cnt = 0;
	int timeout_limit;
	logic verdict_done = 1'b0;

	laser310_top #(.VRAM_AW(VRAM_AW), .RAM_AW(RAM_AW)) dut0
	(
		.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
		.wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
		.key_strobe_i(key_strobe), .key_pressed_i(key_pressed), .key_code_i(key_code),
		.cass_in_i(cass_in), .spk_o(spk), .cass_out_o(cass_out),
		.vdg_ag_o(vdg_ag), .vdg_css_o(vdg_css)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;	// 50 MHz

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		verdict_done = 1'b1;
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_checks.svh"

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Columns of all selected rows ANDed, bit 7 high, bit 6 inverted tape
	function automatic laser310_pkg::byte_t io_read_value(laser310_pkg::byte_t sel);
		laser310_pkg::byte_t cols;
		laser310_pkg::key_mat_t rows;
		cols = 8'hFF;
		rows = keys_m;
		for (int r = 0; r < 8; r++)
		begin
			if (!sel[0])
				cols = cols & rows[7:0];
			sel = sel >> 1;
			rows = rows >> 8;
		end
		return {1'b1, ~cass_m, cols[5:0]};
	endfunction

	// Update the model and append one row
	function automatic void push_step(op_e op, laser310_pkg::addr_t a,
		laser310_pkg::byte_t d, laser310_pkg::byte_t code, logic press);
		step_t s;
		laser310_pkg::addr_t off;
		s.op = op;
		s.addr = a;
		s.data = d;
		s.code = code;
		s.press = press;
		off = (a >= 16'h7800) ? a - 16'h7800 : a - 16'h7000;
		s.exp = 8'hFF;						// Unmapped reads
		if (op == OP_KEY)
		begin
			for (int i = 0; i < KEY_COUNT; i++)
				if (KEY_CODES[i] == code)
					keys_m[KEY_POS[i]] = ~press;	// Other codes ignored
		end
		else if (op == OP_CASS)
			cass_m = d[0];
		else if (a >= 16'h6800 && a <= 16'h6FFF)
		begin
			if (op != OP_RD)
				latch_m = d;
			s.exp = (op == OP_RD) ? io_read_value(a[7:0]) : latch_m;
		end
		else if (a >= 16'h7000 && a <= 16'h77FF)
		begin
			if (op != OP_RD)
				vram_m[off[VRAM_AW-1:0]] = d;
			s.exp = vram_m[off[VRAM_AW-1:0]];
		end
		else if (a >= 16'h7800 && a <= 16'hB7FF)
		begin
			if (op != OP_RD)
				ram_m[off[RAM_AW-1:0]] = d;
			s.exp = ram_m[off[RAM_AW-1:0]];
		end
		steps.push_back(s);
	endfunction

	function automatic void build_table();
		laser310_pkg::addr_t mem_addrs[$];
		laser310_pkg::byte_t presses[$];
		logic [31:0] r;
		mem_addrs = '{16'h7000, 16'h77FF, 16'h7800, 16'hB7FF, 16'h0000, 16'hC000};
		for (int i = 0; i < 12; i++)
		begin
			r = lcg_next();
			mem_addrs.push_back(16'h7000 + {5'b0, r[26:16]});
			r = lcg_next();
			mem_addrs.push_back(16'h7800 + {2'b0, r[29:16]});
		end
		foreach (mem_addrs[i])
		begin
			r = lcg_next();
			push_step(OP_WR, mem_addrs[i], r[23:16], 8'h00, 1'b0);
		end
		foreach (mem_addrs[i])
			push_step(OP_RD, mem_addrs[i], 8'h00, 8'h00, 1'b0);
		push_step(OP_RD, 16'h67FF, 8'h00, 8'h00, 1'b0);		// Just below I/O
		push_step(OP_RD, 16'hB800, 8'h00, 8'h00, 1'b0);		// Just above RAM
		for (int i = 0; i < 8; i++)
		begin
			r = lcg_next();
			push_step(OP_WR_IO, {5'b01101, r[26:16]}, r[31:24], 8'h00, 1'b0);
		end
		// A Q Ctrl Space Return J B, Esc unmapped
		presses = '{8'h1C, 8'h15, 8'h14, 8'h29, 8'h5A, 8'h3B, 8'h32, 8'h76};
		foreach (presses[i])
			push_step(OP_KEY, 16'h0000, 8'h00, presses[i], 1'b1);
		push_step(OP_CASS, 16'h0000, 8'h00, 8'h00, 1'b0);
		for (int i = 0; i < 8; i++)
			push_step(OP_RD, {8'h68, ~(8'h01 << i)}, 8'h00, 8'h00, 1'b0);
		push_step(OP_CASS, 16'h0000, 8'h01, 8'h00, 1'b0);
		push_step(OP_RD, 16'h6800, 8'h00, 8'h00, 1'b0);		// Every row
		push_step(OP_RD, 16'h6FFC, 8'h00, 8'h00, 1'b0);
		push_step(OP_KEY, 16'h0000, 8'h00, 8'h1C, 1'b0);	// Release A, Ctrl, J
		push_step(OP_KEY, 16'h0000, 8'h00, 8'h14, 1'b0);
		push_step(OP_KEY, 16'h0000, 8'h00, 8'h3B, 1'b0);
		push_step(OP_KEY, 16'h0000, 8'h00, 8'h35, 1'b1);	// Press Y
		for (int i = 0; i < 6; i++)
		begin
			r = lcg_next();
			push_step(OP_RD, {5'b01101, r[26:24], r[23:16]}, 8'h00, 8'h00, 1'b0);
		end
	endfunction

	// One Wishbone classic cycle, request on a falling edge
	task automatic bus_access(input logic we, input laser310_pkg::addr_t a,
		input laser310_pkg::byte_t d, output laser310_pkg::byte_t rd);
		int cycles;
		@(negedge CLK50MHZ);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = a;
		wb_wdat = d;
		cycles = 0;
		do
		begin
			@(negedge CLK50MHZ);
			cycles++;
		end
		while (!wb_ack);
		rd = wb_rdat;
		check_ack(cycles);
		@(negedge CLK50MHZ);				// Request held across the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic apply_step(input step_t s);
		laser310_pkg::byte_t rd;
		case (s.op)
			OP_WR:
				bus_access(1'b1, s.addr, s.data, rd);
			OP_WR_IO:
			begin
				bus_access(1'b1, s.addr, s.data, rd);
				check_latch(s.exp);
			end
			OP_RD:
			begin
				bus_access(1'b0, s.addr, 8'h00, rd);
				check_byte("wb_dat_o", rd, s.exp);
			end
			OP_KEY:
			begin
				@(negedge CLK50MHZ);
				key_strobe = 1'b1;
				key_code = s.code;
				key_pressed = s.press;
				@(negedge CLK50MHZ);
				key_strobe = 1'b0;
			end
			default:
			begin
				@(negedge CLK50MHZ);
				cass_in = s.data[0];
			end
		endcase
	endtask

	always @(posedge CLK50MHZ)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit)
			report_failure($sformatf("Timeout, run did not finish in %0d cycles", timeout_limit));
	end

	initial
	begin
		CLK50MHZ = 1'b0;
		RESET_N = 1'b0;
		{wb_cyc, wb_stb, wb_we, key_strobe, key_pressed, cass_in} = '0;
		wb_adr = '0;
		wb_wdat = '0;
		key_code = '0;
		build_table();
		timeout_limit = steps.size() * 6 + RESET_CYCLES + TIMEOUT_MARGIN;
		repeat (RESET_CYCLES) @(negedge CLK50MHZ);
		RESET_N = 1'b1;
		@(negedge CLK50MHZ);
		check_latch(8'h00);
		check_byte("wb_ack_o", {7'b0, wb_ack}, 8'h00);
		foreach (steps[i])
			apply_step(steps[i]);
		$display("ALL TESTS PASSED");
		verdict_done = 1'b1;
		$finish;
	end

	// Run ended before the verdict
	final
	begin
		if (!verdict_done)
			$display("SOME TESTS FAILED");
	end

endmodule

// ==== tb.f ====
+incdir+tb
verilog/laser310_pkg.sv
verilog/mem_bank.sv
verilog/key_matrix.sv
verilog/wb_bus_ctrl.sv
verilog/laser310_top.sv
tb/laser310_properties.sv
tb/tb_laser310.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_laser310
SRCS = $(filter-out +incdir+%,$(shell cat tb.f)) tb/tb_checks.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) tb.f
	verilator --binary --timing --assert --top-module tb_laser310 -f tb.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
